// ==== hw/fu_params.svh ====
`ifndef FU_PARAMS_SVH
`define FU_PARAMS_SVH

// Datapath width, RV32 only
`define FU_XLEN 32

// Tag widths
`define FU_PRN_W 6   // Physical register tag
`define FU_ROBN_W 5  // ROB entry tag

// Finished results held ahead of the CDB
`define FU_FIFO_DEPTH 4

`endif

// ==== hw/fu_pkg.sv ====
`default_nettype none
`include "fu_params.svh"

package fu_pkg;

    typedef logic [`FU_XLEN-1:0] data_t;
    typedef logic [`FU_XLEN-1:0] addr_t;
    typedef logic [`FU_PRN_W-1:0] prn_t;
    typedef logic [`FU_ROBN_W-1:0] robn_t;

    // Encodings follow the decoder
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_func_e;

    typedef enum logic [1:0] {OPA_IS_RS1, OPA_IS_PC, OPA_IS_ZERO} opa_sel_e;

    typedef enum logic [2:0] {
        OPB_IS_RS2, OPB_IS_I_IMM, OPB_IS_S_IMM, OPB_IS_B_IMM, OPB_IS_U_IMM, OPB_IS_J_IMM
    } opb_sel_e;

    // R-type field layout; funct3 sits at the same bits in every format
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_t;

    typedef struct packed {
        logic      valid;
        inst_t     inst;
        addr_t     pc;
        alu_func_e func;
        data_t     op1;          // rs1 value
        data_t     op2;          // rs2 value
        prn_t      dest_prn;
        robn_t     robn;
        opa_sel_e  opa_select;
        opb_sel_e  opb_select;
        logic      cond_branch;
        logic      uncond_branch; // JAL / JALR
    } fu_packet_t;

    typedef struct packed {
        prn_t  dest_prn;
        robn_t robn;
        data_t result;
        logic  is_branch;
        logic  take_branch;
    } fu_result_t;

    typedef struct packed {
        logic  valid;
        prn_t  dest_prn;
        data_t value;
    } cdb_packet_t;

    typedef struct packed {
        robn_t robn;
        logic  executed;
        logic  branch_taken;
        addr_t target_addr;
    } fu_rob_packet_t;

    // Sign-extended immediates
    function automatic data_t imm_i(inst_t inst);
        logic [31:0] w;
        w = inst;
        return {{20{w[31]}}, w[31:20]};
    endfunction

    function automatic data_t imm_s(inst_t inst);
        logic [31:0] w;
        w = inst;
        return {{20{w[31]}}, w[31:25], w[11:7]};
    endfunction

    function automatic data_t imm_b(inst_t inst);
        logic [31:0] w;
        w = inst;
        return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0}; // Halfword aligned
    endfunction

    function automatic data_t imm_u(inst_t inst);
        logic [31:0] w;
        w = inst;
        return {w[31:12], 12'b0};
    endfunction

    function automatic data_t imm_j(inst_t inst);
        logic [31:0] w;
        w = inst;
        return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    endfunction

endpackage

`default_nettype wire

// ==== hw/alu_cond.sv ====
`default_nettype none
`include "fu_params.svh"

module alu_cond (
    input  logic               clock,
    input  logic               arst_n,
    input  fu_pkg::fu_packet_t fu_packet,
    output logic               stage_valid,
    output fu_pkg::fu_result_t stage_result
);

    fu_pkg::data_t opa;                    // Operand A mux out
    fu_pkg::data_t opb;                    // Operand B mux out
    fu_pkg::data_t alu_result;
    logic signed [`FU_XLEN-1:0] signed_opa;
    logic signed [`FU_XLEN-1:0] signed_opb;
    logic signed [`FU_XLEN-1:0] signed_rs1;
    logic signed [`FU_XLEN-1:0] signed_rs2;
    logic [4:0] shamt;
    logic cond_take;                       // Comparator outcome
    fu_pkg::fu_result_t result_d;          // Next stage contents

    assign signed_opa = opa;
    assign signed_opb = opb;
    assign signed_rs1 = fu_packet.op1;
    assign signed_rs2 = fu_packet.op2;
    assign shamt = opb[4:0];               // RV32 shifts use low 5 bits

    // Operand A
    always_comb begin
        case (fu_packet.opa_select)
            fu_pkg::OPA_IS_RS1:  opa = fu_packet.op1;
            fu_pkg::OPA_IS_PC:   opa = fu_packet.pc;   // AUIPC, branches, JAL
            fu_pkg::OPA_IS_ZERO: opa = '0;             // LUI
            default:             opa = '0;
        endcase
    end

    // Operand B, register or immediate
    always_comb begin
        case (fu_packet.opb_select)
            fu_pkg::OPB_IS_RS2:   opb = fu_packet.op2;
            fu_pkg::OPB_IS_I_IMM: opb = fu_pkg::imm_i(fu_packet.inst);
            fu_pkg::OPB_IS_S_IMM: opb = fu_pkg::imm_s(fu_packet.inst);
            fu_pkg::OPB_IS_B_IMM: opb = fu_pkg::imm_b(fu_packet.inst);
            fu_pkg::OPB_IS_U_IMM: opb = fu_pkg::imm_u(fu_packet.inst);
            fu_pkg::OPB_IS_J_IMM: opb = fu_pkg::imm_j(fu_packet.inst);
            default:              opb = '0;      // Codes 6 and 7 unused
        endcase
    end

    // ALU
    always_comb begin
        case (fu_packet.func)
            fu_pkg::ALU_ADD:  alu_result = opa + opb;
            fu_pkg::ALU_SUB:  alu_result = opa - opb;
            fu_pkg::ALU_AND:  alu_result = opa & opb;
            fu_pkg::ALU_OR:   alu_result = opa | opb;
            fu_pkg::ALU_XOR:  alu_result = opa ^ opb;
            fu_pkg::ALU_SLT:  alu_result = fu_pkg::data_t'(signed_opa < signed_opb);
            fu_pkg::ALU_SLTU: alu_result = fu_pkg::data_t'(opa < opb);
            fu_pkg::ALU_SLL:  alu_result = opa << shamt;
            fu_pkg::ALU_SRL:  alu_result = opa >> shamt;
            fu_pkg::ALU_SRA:  alu_result = signed_opa >>> shamt; // Sign fill
            default:          alu_result = '0;
        endcase
    end

    // Branch condition from funct3
    always_comb begin
        case (fu_packet.inst.funct3)
            3'b000:  cond_take = signed_rs1 == signed_rs2;  // BEQ
            3'b001:  cond_take = signed_rs1 != signed_rs2;  // BNE
            3'b100:  cond_take = signed_rs1 <  signed_rs2;  // BLT
            3'b101:  cond_take = signed_rs1 >= signed_rs2;  // BGE
            3'b110:  cond_take = fu_packet.op1 <  fu_packet.op2; // BLTU
            3'b111:  cond_take = fu_packet.op1 >= fu_packet.op2; // BGEU
            default: cond_take = 1'b0;                      // Not a branch encoding
        endcase
    end

    always_comb begin
        result_d.dest_prn    = fu_packet.dest_prn;
        result_d.robn        = fu_packet.robn;
        result_d.result      = alu_result;  // Target address for branches
        result_d.is_branch   = fu_packet.cond_branch | fu_packet.uncond_branch;
        result_d.take_branch = fu_packet.uncond_branch | (fu_packet.cond_branch & cond_take);
    end

    // Output stage, valid strobe
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= fu_packet.valid;
        end
    end

    // Payload only loads with a packet
    always_ff @(posedge clock) begin
        if (fu_packet.valid) begin
            stage_result <= result_d;
        end
    end

    // Issue must only send the ten decoded functions
    a_func_legal: assert property (@(posedge clock) disable iff (!arst_n)
        fu_packet.valid |-> fu_packet.func inside {[fu_pkg::ALU_ADD:fu_pkg::ALU_SRA]})
        else $error("alu_cond: illegal func %0h with valid", fu_packet.func);

endmodule

`default_nettype wire

// ==== hw/result_fifo.sv ====
`default_nettype none
`include "fu_params.svh"

module result_fifo (
    input  logic               clock,
    input  logic               arst_n,
    input  logic               stage_valid,
    input  fu_pkg::fu_result_t stage_result,
    input  logic               pop,
    output fu_pkg::fu_result_t head,
    output logic               not_empty,
    output logic               fu_alu_avail
);

    localparam int fifo_depth = `FU_FIFO_DEPTH;
    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_w = $clog2(fifo_depth + 1);    // Holds 0..depth

    fu_pkg::fu_result_t mem [fifo_depth];             // Entry storage
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic full;

    // Wraps for any depth, not just powers of two
    function automatic logic [ptr_w-1:0] next_ptr(logic [ptr_w-1:0] ptr);
        return (ptr == ptr_w'(fifo_depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full = (count == cnt_w'(fifo_depth));
    assign not_empty = (count != '0);
    assign head = mem[rd_ptr];

    // Reserve a slot for the entry still in the stage register
    assign fu_alu_avail = (int'(count) + int'(stage_valid)) < fifo_depth;

    always_ff @(posedge clock) begin
        if (stage_valid) begin
            mem[wr_ptr] <= stage_result;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (stage_valid) wr_ptr <= next_ptr(wr_ptr);
            if (pop) rd_ptr <= next_ptr(rd_ptr);
            case ({stage_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;                          // Both or neither, no change
            endcase
        end
    end

    // Avail level must keep the stage from ever hitting a full buffer
    a_no_overflow: assert property (@(posedge clock) disable iff (!arst_n)
        stage_valid |-> !full)
        else $error("result_fifo: write while full, count %0h", count);

    a_no_underflow: assert property (@(posedge clock) disable iff (!arst_n)
        pop |-> not_empty)
        else $error("result_fifo: pop while empty");

    // Head holds until the consumer takes it
    a_head_stable: assert property (@(posedge clock) disable iff (!arst_n)
        (not_empty && !pop) |=> $stable(head))
        else $error("result_fifo: head changed without pop");

endmodule

`default_nettype wire

// ==== hw/cdb_broadcast.sv ====
`default_nettype none

module cdb_broadcast (
    input  logic                   cdb_grant,
    input  fu_pkg::fu_result_t     head,
    input  logic                   not_empty,
    output logic                   pop,
    output fu_pkg::cdb_packet_t    cdb_packet,
    output fu_pkg::fu_rob_packet_t fu_rob_packet
);

    logic writes_reg;   // Head targets a real register

    // p0 is hardwired zero and never broadcast
    assign writes_reg = (head.dest_prn != '0);

    // Transfer completes on a granted edge
    assign pop = not_empty & cdb_grant;

    always_comb begin
        cdb_packet.valid    = not_empty & writes_reg;
        cdb_packet.dest_prn = head.dest_prn;
        cdb_packet.value    = head.result;
    end

    // ROB sees every entry including p0 writes and branches
    always_comb begin
        fu_rob_packet.robn         = head.robn;
        fu_rob_packet.executed     = not_empty;
        fu_rob_packet.branch_taken = head.take_branch;
        // ALU computed PC + imm for branch packets
        fu_rob_packet.target_addr  = head.is_branch ? head.result : '0;
    end

endmodule

`default_nettype wire

// ==== hw/fu_exec.sv ====
`default_nettype none

module fu_exec (
    input  logic                   clock,
    input  logic                   arst_n,
    input  fu_pkg::fu_packet_t     fu_packet,
    input  logic                   cdb_grant,
    output logic                   fu_alu_avail,
    output fu_pkg::cdb_packet_t    cdb_packet,
    output fu_pkg::fu_rob_packet_t fu_rob_packet
);

    logic               stage_valid;   // ALU stage to buffer
    fu_pkg::fu_result_t stage_result;
    fu_pkg::fu_result_t head;          // Buffer to broadcast
    logic               not_empty;
    logic               pop;

    // Producer
    alu_cond alu_cond_0 (
        .clock        (clock),
        .arst_n       (arst_n),
        .fu_packet    (fu_packet),
        .stage_valid  (stage_valid),
        .stage_result (stage_result)
    );

    // Buffer, also sources the avail level to issue
    result_fifo result_fifo_0 (
        .clock        (clock),
        .arst_n       (arst_n),
        .stage_valid  (stage_valid),
        .stage_result (stage_result),
        .pop          (pop),
        .head         (head),
        .not_empty    (not_empty),
        .fu_alu_avail (fu_alu_avail)
    );

    // Consumer
    cdb_broadcast cdb_broadcast_0 (
        .cdb_grant     (cdb_grant),
        .head          (head),
        .not_empty     (not_empty),
        .pop           (pop),
        .cdb_packet    (cdb_packet),
        .fu_rob_packet (fu_rob_packet)
    );

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`default_nettype none

module tb_clock (
    output logic clock,
    output logic arst_n
);

    localparam int half_period = 10;   // 20-unit period
    localparam int reset_cycles = 5;

    initial begin
        clock = 1'b0;
        forever #half_period clock = ~clock;
    end

    // Release on a falling edge, clear of the sampling edge
    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tests/tb_fu_exec.sv ====
`default_nettype none
`include "fu_params.svh"

module tb_fu_exec;

    typedef struct packed {
        fu_pkg::fu_result_t res;
        logic [31:0]        accept_cycle;   // Edge that took the packet
    } expect_t;

    localparam int n_alu = 40;
    localparam int n_branch = 32;
    localparam int n_random = 60;
    localparam int n_zero = 12;
    localparam int watchdog_cycles = (n_alu + n_branch + n_random + n_zero) * 40 + 200;

    logic                   clock;
    logic                   arst_n;
    fu_pkg::fu_packet_t     fu_packet;
    logic                   cdb_grant;
    logic                   fu_alu_avail;
    fu_pkg::cdb_packet_t    cdb_packet;
    fu_pkg::fu_rob_packet_t fu_rob_packet;

    logic [31:0] lfsr = 32'h80a0;
    expect_t     exp_q[$];                  // Predicted results in issue order
    logic [31:0] cycle_count = '0;
    int          errors = 0;
    int          checks = 0;
    int          sent = 0;
    int          moved = 0;                 // Granted transfers
    int          avail_low = 0;
    logic        random_grant = 1'b0;
    logic        check_latency = 1'b0;
    logic        hold_pending = 1'b0;       // Last edge saw an entry without grant
    fu_pkg::cdb_packet_t    last_cdb;
    fu_pkg::fu_rob_packet_t last_rob;

    tb_clock clock_gen (.clock(clock), .arst_n(arst_n));

    fu_exec uut (
        .clock         (clock),
        .arst_n        (arst_n),
        .fu_packet     (fu_packet),
        .cdb_grant     (cdb_grant),
        .fu_alu_avail  (fu_alu_avail),
        .cdb_packet    (cdb_packet),
        .fu_rob_packet (fu_rob_packet)
    );

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic check_equal(string name, logic [63:0] got, logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(logic cond, string what);
        checks++;
        assert (cond) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    // Immediate bits moved to the top of the word and shifted down arithmetically for sign fill
    function automatic logic [31:0] predict_opb(fu_pkg::fu_packet_t p);
        logic [31:0] w;
        w = p.inst;
        case (p.opb_select)
            fu_pkg::OPB_IS_RS2:   return p.op2;
            fu_pkg::OPB_IS_I_IMM: return $signed(w) >>> 20;
            fu_pkg::OPB_IS_S_IMM: return $signed({w[31:25], w[11:7], 20'b0}) >>> 20;
            fu_pkg::OPB_IS_B_IMM: return $signed({w[31], w[7], w[30:25], w[11:8], 20'b0}) >>> 19;
            fu_pkg::OPB_IS_U_IMM: return {w[31:12], 12'b0};
            fu_pkg::OPB_IS_J_IMM: return $signed({w[31], w[19:12], w[20], w[30:21], 12'b0}) >>> 11;
            default:              return '0;
        endcase
    endfunction

    function automatic fu_pkg::fu_result_t predict_result(fu_pkg::fu_packet_t p);
        fu_pkg::fu_result_t r;
        logic [31:0] a;
        logic [31:0] b;
        logic taken;
        case (p.opa_select)
            fu_pkg::OPA_IS_RS1: a = p.op1;
            fu_pkg::OPA_IS_PC:  a = p.pc;
            default:            a = '0;
        endcase
        b = predict_opb(p);
        case (p.func)
            fu_pkg::ALU_ADD:  r.result = a + b;
            fu_pkg::ALU_SUB:  r.result = a - b;
            fu_pkg::ALU_AND:  r.result = a & b;
            fu_pkg::ALU_OR:   r.result = a | b;
            fu_pkg::ALU_XOR:  r.result = a ^ b;
            fu_pkg::ALU_SLT:  r.result = {31'b0, $signed(a) < $signed(b)};
            fu_pkg::ALU_SLTU: r.result = {31'b0, a < b};
            fu_pkg::ALU_SLL:  r.result = a << b[4:0];
            fu_pkg::ALU_SRL:  r.result = a >> b[4:0];
            fu_pkg::ALU_SRA:  r.result = $signed(a) >>> b[4:0];
            default:          r.result = '0;
        endcase
        case (p.inst.funct3)
            3'b000:  taken = p.op1 == p.op2;
            3'b001:  taken = p.op1 != p.op2;
            3'b100:  taken = $signed(p.op1) < $signed(p.op2);
            3'b101:  taken = $signed(p.op1) >= $signed(p.op2);
            3'b110:  taken = p.op1 < p.op2;
            3'b111:  taken = p.op1 >= p.op2;
            default: taken = 1'b0;             // 010, 011 never branch
        endcase
        r.dest_prn = p.dest_prn;
        r.robn = p.robn;
        r.is_branch = p.cond_branch || p.uncond_branch;
        r.take_branch = p.uncond_branch || (p.cond_branch && taken);
        return r;
    endfunction

    function automatic fu_pkg::fu_packet_t make_packet();
        fu_pkg::fu_packet_t p;
        p = '0;
        p.valid = 1'b1;
        p.inst = take_bits(32);
        p.pc = {30'(take_bits(30)), 2'b00};
        p.op1 = take_bits(32);
        p.op2 = (take_bits(2) == 32'd0) ? p.op1 : take_bits(32);   // Equal now and then
        p.func = fu_pkg::alu_func_e'(4'(take_bits(4) % 10));
        p.opa_select = fu_pkg::opa_sel_e'(2'(take_bits(2) % 3));
        p.opb_select = fu_pkg::opb_sel_e'(3'(take_bits(3) % 6));
        p.dest_prn = 6'(take_bits(6));
        if (p.dest_prn == '0) p.dest_prn = 6'd1;
        p.robn = 5'(sent);
        return p;
    endfunction

    task automatic drive_grant();
        cdb_grant <= random_grant ? (take_bits(2) == 32'd3) : 1'b1;   // About one in four
    endtask

    // Skip a cycle after each packet so avail seen before the edge still holds after it
    task automatic issue_packet(fu_pkg::fu_packet_t p);
        logic done;
        done = 1'b0;
        while (!done) begin
            @(posedge clock);
            drive_grant();
            if (!fu_packet.valid && fu_alu_avail) begin
                fu_packet <= p;
                sent++;
                done = 1'b1;
            end else begin
                fu_packet.valid <= 1'b0;
            end
        end
    endtask

    task automatic idle_cycle();
        @(posedge clock);
        drive_grant();
        fu_packet.valid <= 1'b0;
    endtask

    task automatic drain_results();
        idle_cycle();
        @(negedge clock);
        while (moved < sent) begin
            idle_cycle();
            @(negedge clock);
        end
        check_true(!fu_rob_packet.executed, "entry still buffered after all transfers");
    endtask

    task automatic report_test(string name, int first_err, int packets);
        $display("%s: %0d packets, %0d errors", name, packets, errors - first_err);
    endtask

    // Samples pre-edge values
    // A transfer is executed plus grant at the edge
    always @(posedge clock) begin : monitor
        expect_t e;
        if (arst_n) begin
            cycle_count = cycle_count + 32'd1;
            check_equal("fu_alu_avail", 64'(fu_alu_avail),
                        64'(exp_q.size() < `FU_FIFO_DEPTH));
            check_true(exp_q.size() <= `FU_FIFO_DEPTH, "more results in flight than buffer slots");
            check_true(!cdb_packet.valid || fu_rob_packet.executed,
                       "CDB valid with no entry present");
            if (!fu_alu_avail) avail_low++;
            if (hold_pending) begin
                check_equal("cdb_packet", 64'(cdb_packet), 64'(last_cdb));
                check_equal("fu_rob_packet", 64'(fu_rob_packet), 64'(last_rob));
            end
            hold_pending = fu_rob_packet.executed && !cdb_grant;
            last_cdb = cdb_packet;
            last_rob = fu_rob_packet;
            if (fu_rob_packet.executed && cdb_grant) begin
                moved++;
                if (exp_q.size() == 0) begin
                    check_true(1'b0, "result transferred with nothing outstanding");
                end else begin
                    e = exp_q.pop_front();
                    check_equal("fu_rob_packet.robn", 64'(fu_rob_packet.robn), 64'(e.res.robn));
                    check_equal("fu_rob_packet.branch_taken", 64'(fu_rob_packet.branch_taken),
                                64'(e.res.take_branch));
                    check_equal("fu_rob_packet.target_addr", 64'(fu_rob_packet.target_addr),
                                e.res.is_branch ? 64'(e.res.result) : 64'd0);
                    check_equal("cdb_packet.valid", 64'(cdb_packet.valid),
                                64'(e.res.dest_prn != '0));   // p0 never broadcast
                    if (e.res.dest_prn != '0) begin
                        check_equal("cdb_packet.dest_prn", 64'(cdb_packet.dest_prn),
                                    64'(e.res.dest_prn));
                        check_equal("cdb_packet.value", 64'(cdb_packet.value), 64'(e.res.result));
                    end
                    if (check_latency) begin
                        check_equal("transfer latency", 64'(cycle_count - e.accept_cycle), 64'd2);
                    end
                end
            end
            if (fu_packet.valid) begin
                check_true(fu_alu_avail, "packet issued while fu_alu_avail was low");
                e.res = predict_result(fu_packet);
                e.accept_cycle = cycle_count;
                exp_q.push_back(e);
            end
        end
    end

    initial begin : stimulus
        int first;
        fu_pkg::fu_packet_t p;
        fu_packet = '0;
        cdb_grant = 1'b0;
        @(posedge arst_n);

        // Quiet outputs before the first packet
        first = errors;
        repeat (3) begin
            @(negedge clock);
            check_equal("cdb_packet.valid", 64'(cdb_packet.valid), 64'd0);
            check_equal("fu_rob_packet.executed", 64'(fu_rob_packet.executed), 64'd0);
            check_equal("fu_alu_avail", 64'(fu_alu_avail), 64'd1);
        end
        report_test("reset", first, 0);

        first = errors;
        check_latency = 1'b1;
        for (int i = 0; i < n_alu; i++) begin
            p = make_packet();
            p.func = fu_pkg::alu_func_e'(4'(i % 10));        // Every function
            p.opa_select = fu_pkg::opa_sel_e'(2'(i % 3));    // And every select
            p.opb_select = fu_pkg::opb_sel_e'(3'(i % 6));
            issue_packet(p);
        end
        drain_results();
        report_test("alu_ops", first, n_alu);

        first = errors;
        for (int i = 0; i < n_branch; i++) begin
            p = make_packet();
            p.inst.funct3 = 3'(i);                           // Unused codes too
            p.func = fu_pkg::ALU_ADD;                        // PC plus offset
            p.opa_select = fu_pkg::OPA_IS_PC;
            p.cond_branch = (i < 24);
            p.uncond_branch = (i >= 24);
            p.opb_select = (i < 24) ? fu_pkg::OPB_IS_B_IMM : fu_pkg::OPB_IS_J_IMM;
            issue_packet(p);
        end
        drain_results();
        report_test("branches", first, n_branch);

        first = errors;
        check_latency = 1'b0;                                // Latency varies under stalls
        random_grant = 1'b1;
        avail_low = 0;
        for (int i = 0; i < n_random; i++) begin
            p = make_packet();
            p.cond_branch = 1'(take_bits(1));
            p.uncond_branch = 1'(take_bits(1));
            issue_packet(p);
        end
        drain_results();
        check_true(avail_low > 0, "fu_alu_avail never fell under random grant");
        report_test("backpressure", first, n_random);

        first = errors;
        random_grant = 1'b0;
        check_latency = 1'b1;
        for (int i = 0; i < n_zero; i++) begin
            p = make_packet();
            p.dest_prn = '0;                                 // Reaches the ROB only
            issue_packet(p);
        end
        drain_results();
        report_test("dest_p0", first, n_zero);

        $display("tests 5, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Forty cycles per packet plus margin
    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clock);
        $display("timeout after %0d cycles with %0d results outstanding",
                 watchdog_cycles, exp_q.size());
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hw
hw/fu_pkg.sv
hw/alu_cond.sv
hw/result_fifo.sv
hw/cdb_broadcast.sv
hw/fu_exec.sv
tests/tb_clock.sv
tests/tb_fu_exec.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fu_exec
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard hw/*.sv hw/*.svh tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^Test OK$$" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
